//--- Bender.yml
package:
  name: noc_mem_link

sources:
  - files:
      - source/noc_pkg.sv
      - source/io_link_pkg.sv
      - source/link_fifo.sv
      - source/wh_concentrator.sv
      - source/link_rr_distributor.sv
      - source/io_channel_link.sv
      - source/noc_mem_link.sv
  - target: test
    files:
      - tests/noc_mem_link_tb.sv

//--- build.f
source/noc_pkg.sv
source/io_link_pkg.sv
source/link_fifo.sv
source/wh_concentrator.sv
source/link_rr_distributor.sv
source/io_channel_link.sv
source/noc_mem_link.sv
tests/noc_mem_link_tb.sv

//--- source/io_channel_link.sv
`timescale 1ns/1ps

module io_channel_link
 #(parameter int io_credits_p = 8
  )
  (input  logic                   core_clk_i
  ,input  logic                   rst_n_i

  ,input  noc_pkg::wh_link_t      core_link_i
  ,output noc_pkg::wh_link_t      core_link_o

  ,output io_link_pkg::io_beat_t  io_beat_o
  ,input  logic                   io_token_i

  ,input  io_link_pkg::io_beat_t  io_beat_i
  ,output logic                   io_token_o
  );

  import noc_pkg::*;
  import io_link_pkg::*;

  localparam int credit_width_lp = $clog2(io_credits_p + 1);
  localparam int tx_cnt_width_lp = $clog2(beats_per_flit_gp + 1);
  localparam int rx_cnt_width_lp = $clog2(beats_per_flit_gp);
  localparam int asm_width_lp    = (beats_per_flit_gp - 1) * beat_width_gp;

  logic [flit_width_gp-1:0]   tx_shift_r;
  logic [tx_cnt_width_lp-1:0] tx_cnt_r;
  logic [credit_width_lp-1:0] credits_r;
  logic                       beat_send, last_send, tx_ready, tx_accept;

  logic                       rx_in_ready, rx_v, rx_pop, last_beat;
  io_beat_t                   rx_beat;
  logic [rx_cnt_width_lp-1:0] rx_cnt_r;
  logic [asm_width_lp-1:0]    asm_r;
  wh_flit_t                   flit_r;
  logic                       flit_v_r, flit_taken, token_r;

  // transmit side sends the lowest beat first
  assign beat_send = (tx_cnt_r != '0) & (credits_r != '0);
  assign last_send = beat_send & (tx_cnt_r == tx_cnt_width_lp'(1));
  assign tx_ready  = ((tx_cnt_r == '0) | last_send) & (credits_r != '0);
  assign tx_accept = core_link_i.v & tx_ready;

  assign io_beat_o = '{v: beat_send, data: tx_shift_r[beat_width_gp-1:0]};

  always_ff @(posedge core_clk_i)
  begin
    if (tx_accept)
      tx_shift_r <= core_link_i.data;
    else if (beat_send)
      tx_shift_r <= tx_shift_r >> beat_width_gp;
  end

  always_ff @(posedge core_clk_i)
  begin
    if (!rst_n_i)
    begin
      tx_cnt_r  <= '0;
      credits_r <= credit_width_lp'(io_credits_p);
    end
    else
    begin
      if (tx_accept)
        tx_cnt_r <= tx_cnt_width_lp'(beats_per_flit_gp);
      else if (beat_send)
        tx_cnt_r <= tx_cnt_r - 1'b1;
      credits_r <= credits_r + credit_width_lp'(io_token_i) - credit_width_lp'(beat_send);
    end
  end

  // receive buffer sized to the credits
  link_fifo
 #(.depth_p   (io_credits_p)
  ,.payload_t (io_beat_t)
  ) rx_fifo
  (.core_clk_i (core_clk_i)
  ,.rst_n_i    (rst_n_i)
  ,.in_v_i     (io_beat_i.v)
  ,.in_data_i  (io_beat_i)
  ,.in_ready_o (rx_in_ready)
  ,.out_v_o    (rx_v)
  ,.out_data_o (rx_beat)
  ,.out_ready_i(rx_pop)
  );

  assign last_beat  = (rx_cnt_r == rx_cnt_width_lp'(beats_per_flit_gp - 1));
  assign flit_taken = flit_v_r & core_link_i.ready_and;
  // only the final beat waits for the output register
  assign rx_pop     = rx_v & (~last_beat | ~flit_v_r | flit_taken);

  always_ff @(posedge core_clk_i)
  begin
    if (rx_pop)
    begin
      if (last_beat)
        flit_r <= wh_flit_t'({rx_beat.data, asm_r});
      else
        asm_r <= {rx_beat.data, asm_r[asm_width_lp-1:beat_width_gp]};
    end
  end

  always_ff @(posedge core_clk_i)
  begin
    if (!rst_n_i)
    begin
      rx_cnt_r <= '0;
      flit_v_r <= 1'b0;
      token_r  <= 1'b0;
    end
    else
    begin
      token_r <= rx_pop;
      if (rx_pop)
        rx_cnt_r <= last_beat ? '0 : rx_cnt_r + 1'b1;
      if (rx_pop && last_beat)
        flit_v_r <= 1'b1;
      else if (flit_taken)
        flit_v_r <= 1'b0;
    end
  end

  assign io_token_o  = token_r;
  assign core_link_o = '{v: flit_v_r, data: flit_r, ready_and: tx_ready};

  credit_bound_a: assert property (@(posedge core_clk_i) disable iff (!rst_n_i)
    credits_r <= credit_width_lp'(io_credits_p))
    else $error("credit counter above %0d", io_credits_p);

  // far side must respect our credits
  no_beat_drop_a: assert property (@(posedge core_clk_i) disable iff (!rst_n_i)
    io_beat_i.v |-> rx_in_ready)
    else $error("beat arrived with receive buffer full");

endmodule

//--- source/io_link_pkg.sv
package io_link_pkg;

  localparam int beat_width_gp = 8;

  // beats needed to carry one wormhole flit
  localparam int beats_per_flit_gp = noc_pkg::flit_width_gp / beat_width_gp;

  typedef struct packed {
    logic                     v;
    logic [beat_width_gp-1:0] data;
  } io_beat_t;

endpackage

//--- source/link_fifo.sv
`timescale 1ns/1ps

module link_fifo
 #(parameter int  depth_p   = 2
  ,parameter type payload_t = logic [7:0]
  )
  (input  logic     core_clk_i
  ,input  logic     rst_n_i

  ,input  logic     in_v_i
  ,input  payload_t in_data_i
  ,output logic     in_ready_o

  ,output logic     out_v_o
  ,output payload_t out_data_o
  ,input  logic     out_ready_i
  );

  localparam int ptr_width_lp = (depth_p > 1) ? $clog2(depth_p) : 1;
  localparam int cnt_width_lp = $clog2(depth_p + 1);

  payload_t                mem_r [depth_p];
  logic [ptr_width_lp-1:0] wr_ptr_r, rd_ptr_r;
  logic [cnt_width_lp-1:0] count_r;
  logic                    full, empty, wr_en, rd_en;

  assign full  = (count_r == cnt_width_lp'(depth_p));
  assign empty = (count_r == '0);
  assign wr_en = in_v_i & ~full;
  assign rd_en = out_ready_i & ~empty;

  assign in_ready_o = ~full;
  assign out_v_o    = ~empty;
  assign out_data_o = mem_r[rd_ptr_r];

  always_ff @(posedge core_clk_i)
  begin
    if (wr_en)
      mem_r[wr_ptr_r] <= in_data_i;
  end

  always_ff @(posedge core_clk_i)
  begin
    if (!rst_n_i)
    begin
      wr_ptr_r <= '0;
      rd_ptr_r <= '0;
      count_r  <= '0;
    end
    else
    begin
      // pointers wrap at depth_p rather than a power of two
      if (wr_en)
        wr_ptr_r <= (wr_ptr_r == ptr_width_lp'(depth_p - 1)) ? '0 : wr_ptr_r + 1'b1;
      if (rd_en)
        rd_ptr_r <= (rd_ptr_r == ptr_width_lp'(depth_p - 1)) ? '0 : rd_ptr_r + 1'b1;
      count_r <= count_r + cnt_width_lp'(wr_en) - cnt_width_lp'(rd_en);
    end
  end

  no_write_when_full_a: assert property (@(posedge core_clk_i) disable iff (!rst_n_i)
    count_r <= cnt_width_lp'(depth_p))
    else $error("link_fifo took a write while full");

endmodule

//--- source/link_rr_distributor.sv
`timescale 1ns/1ps

module link_rr_distributor
 #(parameter int num_channels_p = 2
  )
  (input  logic                                     core_clk_i
  ,input  logic                                     rst_n_i

  ,input  noc_pkg::wh_link_t                        single_link_i
  ,output noc_pkg::wh_link_t                        single_link_o

  ,input  noc_pkg::wh_link_t [num_channels_p-1:0]   chan_links_i
  ,output noc_pkg::wh_link_t [num_channels_p-1:0]   chan_links_o
  );

  import noc_pkg::*;

  localparam int lg_chan_lp = (num_channels_p > 1) ? $clog2(num_channels_p) : 1;

  logic [lg_chan_lp-1:0] send_ptr_r, gather_ptr_r;
  len_t                  send_rem_r, gather_rem_r;
  logic                  send_go, gather_go;
  wh_flit_t              gather_flit;

  function automatic logic [lg_chan_lp-1:0] step_ptr(logic [lg_chan_lp-1:0] ptr);
    return (ptr == lg_chan_lp'(num_channels_p - 1)) ? '0 : lg_chan_lp'(ptr + 1'b1);
  endfunction

  assign gather_flit = chan_links_i[gather_ptr_r].data;
  assign send_go     = single_link_i.v & chan_links_i[send_ptr_r].ready_and;
  assign gather_go   = chan_links_i[gather_ptr_r].v & single_link_i.ready_and;

  assign single_link_o = '{v:         chan_links_i[gather_ptr_r].v
                          ,data:      gather_flit
                          ,ready_and: chan_links_i[send_ptr_r].ready_and};

  always_comb
  begin
    for (int i = 0; i < num_channels_p; i++)
    begin
      chan_links_o[i].v         = single_link_i.v & (send_ptr_r == lg_chan_lp'(i));
      chan_links_o[i].data      = single_link_i.data;
      chan_links_o[i].ready_and = single_link_i.ready_and & (gather_ptr_r == lg_chan_lp'(i));
    end
  end

  // pointers only move past a packet's last flit
  always_ff @(posedge core_clk_i)
  begin
    if (!rst_n_i)
    begin
      send_ptr_r   <= '0;
      send_rem_r   <= '0;
      gather_ptr_r <= '0;
      gather_rem_r <= '0;
    end
    else
    begin
      if (send_go)
      begin
        send_rem_r <= next_remaining(send_rem_r, single_link_i.data);
        if (is_last_flit(send_rem_r, single_link_i.data))
          send_ptr_r <= step_ptr(send_ptr_r);
      end
      if (gather_go)
      begin
        gather_rem_r <= next_remaining(gather_rem_r, gather_flit);
        if (is_last_flit(gather_rem_r, gather_flit))
          gather_ptr_r <= step_ptr(gather_ptr_r);
      end
    end
  end

endmodule

//--- source/noc_mem_link.sv
`timescale 1ns/1ps

module noc_mem_link
 #(parameter int num_wh_links_p = 4
  ,parameter int num_channels_p = 2
  ,parameter int io_credits_p   = 8
  ,parameter int depth_p        = 2
  )
  (input  logic                                         core_clk_i
  ,input  logic                                         rst_n_i

  ,input  noc_pkg::wh_link_t     [num_wh_links_p-1:0]   wh_links_i
  ,output noc_pkg::wh_link_t     [num_wh_links_p-1:0]   wh_links_o

  ,input  io_link_pkg::io_beat_t [num_channels_p-1:0]   io_beat_i
  ,output io_link_pkg::io_beat_t [num_channels_p-1:0]   io_beat_o
  ,input  logic                  [num_channels_p-1:0]   io_token_i
  ,output logic                  [num_channels_p-1:0]   io_token_o
  );

  import noc_pkg::*;

  wh_link_t                      conc_to_rr, rr_to_conc;
  wh_link_t [num_channels_p-1:0] rr_to_chan, chan_to_rr;

  wh_concentrator
 #(.num_wh_links_p(num_wh_links_p)
  ,.depth_p       (depth_p)
  ) conc
  (.core_clk_i (core_clk_i)
  ,.rst_n_i    (rst_n_i)
  ,.wh_links_i (wh_links_i)
  ,.wh_links_o (wh_links_o)
  ,.conc_link_i(rr_to_conc)
  ,.conc_link_o(conc_to_rr)
  );

  link_rr_distributor
 #(.num_channels_p(num_channels_p)
  ) rr
  (.core_clk_i   (core_clk_i)
  ,.rst_n_i      (rst_n_i)
  ,.single_link_i(conc_to_rr)
  ,.single_link_o(rr_to_conc)
  ,.chan_links_i (chan_to_rr)
  ,.chan_links_o (rr_to_chan)
  );

  for (genvar i = 0; i < num_channels_p; i++)
  begin: chan
    io_channel_link
   #(.io_credits_p(io_credits_p)
    ) link
    (.core_clk_i (core_clk_i)
    ,.rst_n_i    (rst_n_i)
    ,.core_link_i(rr_to_chan[i])
    ,.core_link_o(chan_to_rr[i])
    ,.io_beat_o  (io_beat_o[i])
    ,.io_token_i (io_token_i[i])
    ,.io_beat_i  (io_beat_i[i])
    ,.io_token_o (io_token_o[i])
    );
  end

endmodule

//--- source/noc_pkg.sv
package noc_pkg;

  localparam int flit_width_gp = 32;
  localparam int len_width_gp  = 4;
  localparam int cid_width_gp  = 2;

  typedef logic [len_width_gp-1:0] len_t;
  typedef logic [cid_width_gp-1:0] cid_t;

  // len sits in the lowest header bits
  typedef struct packed {
    logic [flit_width_gp-cid_width_gp-len_width_gp-1:0] payload;
    cid_t                                               cid;
    len_t                                               len;
  } wh_flit_t;

  typedef struct packed {
    logic     v;
    wh_flit_t data;
    logic     ready_and;
  } wh_link_t;

  // remaining is zero while a header is expected
  function automatic len_t next_remaining(len_t remaining, wh_flit_t flit);
    return (remaining == '0) ? flit.len : len_t'(remaining - 1'b1);
  endfunction

  function automatic logic is_last_flit(len_t remaining, wh_flit_t flit);
    return (remaining == '0) ? (flit.len == '0) : (remaining == len_t'(1));
  endfunction

endpackage

//--- source/wh_concentrator.sv
`timescale 1ns/1ps

module wh_concentrator
 #(parameter int num_wh_links_p = 4
  ,parameter int depth_p        = 2
  )
  (input  logic                                     core_clk_i
  ,input  logic                                     rst_n_i

  ,input  noc_pkg::wh_link_t [num_wh_links_p-1:0]   wh_links_i
  ,output noc_pkg::wh_link_t [num_wh_links_p-1:0]   wh_links_o

  ,input  noc_pkg::wh_link_t                        conc_link_i
  ,output noc_pkg::wh_link_t                        conc_link_o
  );

  import noc_pkg::*;

  localparam int lg_links_lp = (num_wh_links_p > 1) ? $clog2(num_wh_links_p) : 1;

  logic [lg_links_lp-1:0] rr_last_r, sel_r, pick, grant;
  logic                   locked_r, any_v, fwd_v, fwd_go, fwd_last;
  len_t                   fwd_rem_r;
  wh_flit_t               fwd_flit;

  logic                   ret_in_ready, ret_v, ret_ready, ret_go;
  wh_flit_t               ret_flit;
  len_t                   ret_rem_r;
  cid_t                   ret_sel_r, ret_route;

  // round robin starting after the last winner
  always_comb
  begin
    int idx;
    pick  = rr_last_r;
    any_v = 1'b0;
    for (int off = 1; off <= num_wh_links_p; off++)
    begin
      idx = (int'(rr_last_r) + off) % num_wh_links_p;
      if (!any_v && wh_links_i[idx].v)
      begin
        any_v = 1'b1;
        pick  = lg_links_lp'(idx);
      end
    end
  end

  assign grant    = locked_r ? sel_r : pick;
  assign fwd_v    = locked_r ? wh_links_i[sel_r].v : any_v;
  assign fwd_flit = wh_links_i[grant].data;
  assign fwd_go   = fwd_v & conc_link_i.ready_and;
  assign fwd_last = is_last_flit(fwd_rem_r, fwd_flit);

  always_ff @(posedge core_clk_i)
  begin
    if (!rst_n_i)
    begin
      locked_r  <= 1'b0;
      sel_r     <= '0;
      rr_last_r <= lg_links_lp'(num_wh_links_p - 1);
      fwd_rem_r <= '0;
    end
    else
    begin
      if (fwd_go)
        fwd_rem_r <= next_remaining(fwd_rem_r, fwd_flit);
      // lock as soon as a header shows up, hold until its last flit
      if (!locked_r && any_v)
      begin
        sel_r    <= pick;
        locked_r <= ~(fwd_go & fwd_last);
      end
      else if (locked_r && fwd_go && fwd_last)
        locked_r <= 1'b0;
      if (fwd_go && fwd_last)
        rr_last_r <= grant;
    end
  end

  link_fifo
 #(.depth_p   (depth_p)
  ,.payload_t (wh_flit_t)
  ) ret_fifo
  (.core_clk_i (core_clk_i)
  ,.rst_n_i    (rst_n_i)
  ,.in_v_i     (conc_link_i.v)
  ,.in_data_i  (conc_link_i.data)
  ,.in_ready_o (ret_in_ready)
  ,.out_v_o    (ret_v)
  ,.out_data_o (ret_flit)
  ,.out_ready_i(ret_ready)
  );

  // route from the header cid, then held for the body
  assign ret_route = (ret_rem_r == '0) ? ret_flit.cid : ret_sel_r;
  assign ret_ready = wh_links_i[ret_route].ready_and;
  assign ret_go    = ret_v & ret_ready;

  always_ff @(posedge core_clk_i)
  begin
    if (!rst_n_i)
    begin
      ret_rem_r <= '0;
      ret_sel_r <= '0;
    end
    else if (ret_go)
    begin
      ret_rem_r <= next_remaining(ret_rem_r, ret_flit);
      if (ret_rem_r == '0)
        ret_sel_r <= ret_flit.cid;
    end
  end

  assign conc_link_o = '{v: fwd_v, data: fwd_flit, ready_and: ret_in_ready};

  always_comb
  begin
    for (int i = 0; i < num_wh_links_p; i++)
    begin
      wh_links_o[i].v         = ret_v & (ret_route == cid_t'(i));
      wh_links_o[i].data      = ret_flit;
      wh_links_o[i].ready_and = (grant == lg_links_lp'(i)) & conc_link_i.ready_and;
    end
  end

  cid_in_range_a: assert property (@(posedge core_clk_i) disable iff (!rst_n_i)
    (ret_v && ret_rem_r == '0) |-> (ret_flit.cid < num_wh_links_p))
    else $error("return header cid %0h out of range", ret_flit.cid);

  // merged output must hold while stalled
  fwd_hold_a: assert property (@(posedge core_clk_i) disable iff (!rst_n_i)
    (fwd_v && !conc_link_i.ready_and) |=> (fwd_v && $stable(fwd_flit)))
    else $error("concentrated flit changed while stalled");

endmodule

//--- tests/noc_mem_link_stim.txt
// columns: source link, cid, len, header payload, then len body words (all hex)
// header flit is {payload[25:0], cid[1:0], len[3:0]}; a lone ff ends the list
0 2 3 00a1b2c3 11110001 11110002 11110003
1 0 0 00000c01
2 3 5 02345678 deadbeef 01234567 89abcdef fedcba98 76543210
3 1 2 01000003 a5a5a5a5 5a5a5a5a
0 0 1 00000105 0000ffff
1 3 4 03ffffff 00000000 ffffffff 80000001 7ffffffe
2 1 0 00ab0007
3 2 6 00000208 c0de0001 c0de0002 c0de0003 c0de0004 c0de0005 c0de0006
0 1 7 01010109 10203040 50607080 90a0b0c0 d0e0f001 12345678 9abcdef0 0fedcba9
1 2 1 0002020a cafef00d
2 0 2 0030300b 00000001 00000002
3 3 0 0040400c
0 3 4 0050500d 13579bdf 2468ace0 0f0f0f0f f0f0f0f0
1 1 3 0060600e 33333333 44444444 55555555
2 2 7 0070700f 00010001 00020002 00030003 00040004 00050005 00060006 00070007
3 0 1 00808010 abcdef01
0 2 0 00909011
1 0 5 00a0a012 01010101 02020202 03030303 04040404 05050505
2 3 2 00b0b013 feedface baadf00d
3 1 4 00c0c014 11223344 55667788 99aabbcc ddeeff00
0 0 6 00d0d015 a0000001 a0000002 a0000003 a0000004 a0000005 a0000006
1 3 0 00e0e016
2 1 3 00f0f017 87654321 0badcafe 600dd00d
3 2 2 01111118 e1e2e3e4 f5f6f7f8
0 1 1 01212119 00c0ffee
1 2 6 0131311a 10000000 20000000 30000000 40000000 50000000 60000000
2 0 0 0141411b
3 3 5 0151511c 9999aaaa bbbbcccc ddddeeee ffff0000 12121212
ff

//--- tests/noc_mem_link_tb.sv
`timescale 1ns/1ps

module noc_mem_link_tb;

  import noc_pkg::*;
  import io_link_pkg::*;

  localparam int          num_links_lp  = 4;
  localparam int          num_chan_lp   = 2;
  localparam int          credits_lp    = 8;
  localparam int          stim_words_lp = 1024;
  localparam int unsigned seed_lp       = 32'hf359_82cf;

  logic                        clk = 1'b0;
  logic                        rst_n;
  wh_link_t [num_links_lp-1:0] wh_in, wh_out;
  io_beat_t [num_chan_lp-1:0]  beats;
  logic     [num_chan_lp-1:0]  tokens;

  logic [31:0] stim_mem [stim_words_lp];
  int          pkt_src_q[$], pkt_first_q[$], pkt_flits_q[$];
  logic [31:0] flit_q[$], hdr_sent_q[$];
  logic [31:0] exp_q [num_links_lp][$];
  int          total_flits, sent_flits, ret_flits, value_errs, other_errs;
  int          cycles, limit_cycles;
  logic        started, reset_seen;
  len_t        ret_rem [num_links_lp];
  len_t        chan_rem [num_chan_lp];
  int          outstanding [num_chan_lp], beat_cnt [num_chan_lp], next_hdr [num_chan_lp];
  logic [31:0] beat_asm [num_chan_lp];

  // beats and tokens looped back per channel
  noc_mem_link
 #(.num_wh_links_p(num_links_lp)
  ,.num_channels_p(num_chan_lp)
  ,.io_credits_p  (credits_lp)
  ) noc_mem_link_i
  (.core_clk_i(clk)
  ,.rst_n_i   (rst_n)
  ,.wh_links_i(wh_in)
  ,.wh_links_o(wh_out)
  ,.io_beat_i (beats)
  ,.io_beat_o (beats)
  ,.io_token_i(tokens)
  ,.io_token_o(tokens)
  );

  always #4 clk = ~clk;

  always @(posedge clk)
  begin
    cycles++;
    if (limit_cycles > 0 && cycles > limit_cycles)
    begin
      $display("timeout after %0d cycles with %0d of %0d flits returned",
               cycles, ret_flits, total_flits);
      $display("errors: %0d value, %0d other", value_errs, other_errs);
      $display("*** FAILED ***");
      $finish;
    end
  end

  task automatic load_packets();
    int       idx;
    int       len;
    wh_flit_t hdr;
    $readmemh("tests/noc_mem_link_stim.txt", stim_mem);
    idx = 0;
    while (idx < stim_words_lp && !$isunknown(stim_mem[idx]) && stim_mem[idx] != 32'hff)
    begin
      len         = int'(stim_mem[idx+2][len_width_gp-1:0]);
      hdr.len     = len_t'(len);
      hdr.cid     = cid_t'(stim_mem[idx+1]);
      hdr.payload = stim_mem[idx+3][flit_width_gp-cid_width_gp-len_width_gp-1:0];
      assert (stim_mem[idx] < num_links_lp)
      else
      begin
        other_errs++;
        $display("packet at word %0d has a bad source link", idx);
      end
      pkt_src_q.push_back(int'(stim_mem[idx]));
      pkt_first_q.push_back(flit_q.size());
      pkt_flits_q.push_back(len + 1);
      flit_q.push_back(hdr);
      for (int b = 0; b < len; b++)
        flit_q.push_back(stim_mem[idx+4+b]);
      idx += 4 + len;
    end
    assert (idx < stim_words_lp && stim_mem[idx] == 32'hff)
    else
    begin
      other_errs++;
      $display("packet list has no end marker");
    end
    total_flits = flit_q.size();
  endtask

  // drives one wormhole source in file order
  task automatic send_link(input int link);
    wh_flit_t flit;
    cid_t     dest;
    for (int p = 0; p < pkt_src_q.size(); p++)
    begin
      if (pkt_src_q[p] != link)
        continue;
      dest = flit_q[pkt_first_q[p]][len_width_gp +: cid_width_gp];
      for (int f = 0; f < pkt_flits_q[p]; f++)
      begin
        flit = flit_q[pkt_first_q[p] + f];
        @(negedge clk);
        wh_in[link].v    = 1'b1;
        wh_in[link].data = flit;
        started          = 1'b1;
        do
          @(posedge clk);
        while (!wh_out[link].ready_and);
        if (f == 0)
          hdr_sent_q.push_back(flit);
        exp_q[dest].push_back(flit);
        sent_flits++;
      end
      @(negedge clk);
      wh_in[link].v = 1'b0;
    end
  endtask

  task automatic drive_ready();
    forever
    begin
      @(negedge clk);
      for (int o = 0; o < num_links_lp; o++)
        wh_in[o].ready_and = ($urandom % 4) != 0;
    end
  endtask

  task automatic check_return(input int out, input wh_flit_t flit);
    logic [31:0] exp;
    ret_flits++;
    if (ret_rem[out] == '0)
    begin
      assert (flit.cid == cid_t'(out))
      else
      begin
        value_errs++;
        $display("[ERROR] wh_links_o[%0d].data.cid got 0x%0h expected 0x%0h",
                 out, flit.cid, out);
      end
      ret_rem[out] = flit.len;
    end
    else
      ret_rem[out] = ret_rem[out] - 1'b1;
    assert (exp_q[out].size() > 0)
    else
    begin
      other_errs++;
      $display("flit came back on output %0d with none pending", out);
    end
    if (exp_q[out].size() > 0)
    begin
      exp = exp_q[out].pop_front();
      assert (flit == exp)
      else
      begin
        value_errs++;
        $display("[ERROR] wh_links_o[%0d].data got 0x%08h expected 0x%08h", out, flit, exp);
      end
    end
  endtask

  task automatic watch_channel(input int c);
    wh_flit_t flit;
    outstanding[c] += int'(beats[c].v) - int'(tokens[c]);
    assert (outstanding[c] <= credits_lp)
    else
    begin
      other_errs++;
      $display("channel %0d has %0d beats outstanding, over its credits", c, outstanding[c]);
    end
    if (beats[c].v)
    begin
      // lowest beat first
      beat_asm[c] = {beats[c].data, beat_asm[c][flit_width_gp-1:beat_width_gp]};
      beat_cnt[c]++;
      if (beat_cnt[c] == beats_per_flit_gp)
      begin
        beat_cnt[c] = 0;
        flit        = beat_asm[c];
        if (chan_rem[c] == '0)
        begin
          assert (next_hdr[c] < hdr_sent_q.size())
          else
          begin
            other_errs++;
            $display("header on channel %0d before it was sent", c);
          end
          if (next_hdr[c] < hdr_sent_q.size())
          begin
            assert (flit == hdr_sent_q[next_hdr[c]])
            else
            begin
              value_errs++;
              $display("[ERROR] io_beat_o[%0d] header got 0x%08h expected 0x%08h",
                       c, flit, hdr_sent_q[next_hdr[c]]);
            end
          end
          chan_rem[c] = flit.len;
          next_hdr[c] += num_chan_lp;
        end
        else
          chan_rem[c] = chan_rem[c] - 1'b1;
      end
    end
  endtask

  always @(posedge clk)
  begin
    if (reset_seen && !started)
    begin
      for (int o = 0; o < num_links_lp; o++)
      begin
        assert (!wh_out[o].v)
        else
        begin
          value_errs++;
          $display("[ERROR] wh_links_o[%0d].v got 0x%0h expected 0x0", o, wh_out[o].v);
        end
      end
      for (int c = 0; c < num_chan_lp; c++)
      begin
        assert (!beats[c].v)
        else
        begin
          value_errs++;
          $display("[ERROR] io_beat_o[%0d].v got 0x%0h expected 0x0", c, beats[c].v);
        end
      end
    end
    if (rst_n && reset_seen)
    begin
      for (int o = 0; o < num_links_lp; o++)
        if (wh_out[o].v && wh_in[o].ready_and)
          check_return(o, wh_out[o].data);
      for (int c = 0; c < num_chan_lp; c++)
        watch_channel(c);
    end
    if (!rst_n)
      reset_seen = 1'b1;
  end

  initial
  begin
    void'($urandom(seed_lp));
    rst_n      = 1'b0;
    wh_in      = '0;
    started    = 1'b0;
    reset_seen = 1'b0;
    for (int o = 0; o < num_links_lp; o++)
      ret_rem[o] = '0;
    for (int c = 0; c < num_chan_lp; c++)
    begin
      next_hdr[c] = c;
      chan_rem[c] = '0;
    end
    load_packets();
    limit_cycles = 40 * total_flits;
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    fork
      drive_ready();
    join_none
    for (int l = 0; l < num_links_lp; l++)
    begin
      fork
        automatic int link = l;
        send_link(link);
      join_none
    end
    wait (ret_flits == total_flits);
    // catch any extra flits
    repeat (20) @(posedge clk);
    assert (sent_flits == total_flits && ret_flits == total_flits)
    else
    begin
      other_errs++;
      $display("flit counts differ from the packet list");
    end
    for (int o = 0; o < num_links_lp; o++)
    begin
      assert (exp_q[o].size() == 0)
      else
      begin
        other_errs++;
        $display("output %0d still owes %0d flits", o, exp_q[o].size());
      end
    end
    $display("errors: %0d value, %0d other; flits sent %0d, returned %0d, listed %0d",
             value_errs, other_errs, sent_flits, ret_flits, total_flits);
    if (value_errs == 0 && other_errs == 0)
      $display("*** PASSED ***");
    else
      $display("*** FAILED ***");
    $finish;
  end

endmodule
